// ==== source/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data path and address width
`define XLEN 32

// register index width, 32 architectural registers
`define REG_ADDR_W 5

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// byte distance between two instructions
`define PC_STEP 32'd4

`endif

// ==== source/rv_pkg.sv ====
`include "rv_cfg.svh"

package rv_pkg;

  typedef logic [`XLEN-1:0]       xword_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0, // zero so a bubble decodes as add
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5
  } alu_op_e;

  // execute operand source
  typedef enum logic [1:0] {
    FWD_REG    = 2'd0,
    FWD_EX_MEM = 2'd1,
    FWD_MEM_WB = 2'd2
  } fwd_sel_e;

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    alu_src_imm; // second operand is the immediate
    logic    branch;
    logic    branch_ne;   // bne instead of beq
    logic    jump;
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    logic   valid;
    xword_t pc;
    xword_t instr;
  } if_id_t;

  typedef struct packed {
    ctrl_t     ctrl;
    xword_t    pc;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    xword_t    rs1_data;
    xword_t    rs2_data;
    xword_t    imm;
  } id_ex_t;

  typedef struct packed {
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      mem_to_reg;
    reg_addr_t rd;
    xword_t    result;     // alu result, or link pc for jal
    xword_t    store_data;
  } ex_mem_t;

  typedef struct packed {
    logic      reg_write;
    reg_addr_t rd;
    xword_t    data;
  } mem_wb_t;

  // retired register write
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    xword_t    data;
  } wb_t;

endpackage

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module fetch_unit
  import rv_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   stall,
  input  logic   redirect,
  input  xword_t redirect_pc,
  output xword_t imem_addr,
  input  xword_t imem_data,
  output if_id_t if_id
);

  xword_t pc;

  assign imem_addr = pc; // imem answers in the same cycle

  // redirect wins over stall, the stalled slot is squashed anyway
  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= `RESET_PC;
      if_id.valid <= 1'b0;
    end else if (redirect) begin
      pc          <= redirect_pc;
      if_id.valid <= 1'b0; // kill the word fetched down the wrong path
    end else if (!stall) begin
      pc          <= pc + `PC_STEP;
      if_id.valid <= 1'b1;
      if_id.pc    <= pc;
      if_id.instr <= imem_data;
    end
  end

  // targets come from execute, offsets must keep word alignment
  a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
    pc[1:0] == 2'b00);

endmodule

// ==== source/decode_unit.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module decode_unit
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  if_id_t    if_id,
  input  logic      stall,
  input  logic      redirect,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  input  xword_t    rs1_data,
  input  xword_t    rs2_data,
  output id_ex_t    id_ex
);

  xword_t    instr;
  ctrl_t     ctrl;
  xword_t    imm;
  logic      use_rs1;
  logic      use_rs2;
  logic      bubble;
  reg_addr_t rd;

  function automatic alu_op_e funct3_to_alu(input logic [2:0] funct3);
    case (funct3)
      3'b010:  return ALU_SLT;
      3'b100:  return ALU_XOR;
      3'b110:  return ALU_OR;
      3'b111:  return ALU_AND;
      default: return ALU_ADD;
    endcase
  endfunction

  assign instr = if_id.instr;

  always_comb begin
    ctrl    = '0;
    imm     = '0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (instr[6:0])
      OPC_OP: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = funct3_to_alu(instr[14:12]);
        if (instr[14:12] == 3'b000 && instr[30])
          ctrl.alu_op = ALU_SUB;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      OPC_OP_IMM: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = funct3_to_alu(instr[14:12]);
        imm     = {{(`XLEN-12){instr[31]}}, instr[31:20]};
        use_rs1 = 1'b1;
      end
      OPC_LOAD: begin
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.mem_to_reg  = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        imm     = {{(`XLEN-12){instr[31]}}, instr[31:20]};
        use_rs1 = 1'b1;
      end
      OPC_STORE: begin
        ctrl.mem_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        imm     = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
        use_rs1 = 1'b1;
        use_rs2 = 1'b1; // store data
      end
      OPC_BRANCH: begin
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = instr[12]; // funct3 001 is bne
        ctrl.alu_op    = ALU_SUB;
        imm = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
               instr[11:8], 1'b0};
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      OPC_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        imm = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
               instr[30:21], 1'b0};
      end
      default: ; // unknown opcode decodes as a bubble
    endcase
  end

  // unused source fields read as x0, no false hazard
  assign rs1_addr = (if_id.valid && use_rs1) ? instr[19:15] : '0;
  assign rs2_addr = (if_id.valid && use_rs2) ? instr[24:20] : '0;
  assign rd       = ctrl.reg_write ? instr[11:7] : '0;
  assign bubble   = stall || redirect || !if_id.valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex.ctrl <= '0;
    end else begin
      id_ex.ctrl     <= bubble ? '0 : ctrl;
      id_ex.pc       <= if_id.pc;
      id_ex.rs1      <= rs1_addr;
      id_ex.rs2      <= rs2_addr;
      id_ex.rd       <= rd;
      id_ex.rs1_data <= rs1_data;
      id_ex.rs2_data <= rs2_data;
      id_ex.imm      <= imm;
    end
  end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module reg_file
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  output xword_t    rs1_data,
  output xword_t    rs2_data,
  input  wb_t       wb
);

  localparam int unsigned NUM_REGS = 1 << `REG_ADDR_W;

  xword_t regs [1:NUM_REGS-1]; // no storage for x0

  function automatic xword_t read_port(input reg_addr_t addr);
    if (addr == '0)
      return '0;
    else if (wb.valid && wb.rd == addr)
      return wb.data; // write-through, decode sees the retiring value
    else
      return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (wb.valid && wb.rd != '0)
      regs[wb.rd] <= wb.data;
  end

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  // writeback stage filters x0 before it gets here
  a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
    wb.valid |-> wb.rd != '0);

endmodule

// ==== source/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit
  import rv_pkg::*;
(
  input  reg_addr_t id_rs1,
  input  reg_addr_t id_rs2,
  input  id_ex_t    id_ex,
  input  ex_mem_t   ex_mem,
  input  wb_t       wb,
  output logic      stall,
  output fwd_sel_e  fwd_a,
  output fwd_sel_e  fwd_b
);

  logic ex_mem_hit_ok;
  logic load_in_ex;

  // youngest producer wins
  function automatic fwd_sel_e pick_src(input reg_addr_t src, input logic ex_ok,
                                        input reg_addr_t ex_rd, input wb_t w);
    if (ex_ok && src != '0 && src == ex_rd)
      return FWD_EX_MEM;
    else if (w.valid && src == w.rd)
      return FWD_MEM_WB;
    else
      return FWD_REG;
  endfunction

  // a load in EX/MEM only holds its address
  assign ex_mem_hit_ok = ex_mem.reg_write && !ex_mem.mem_read;

  assign fwd_a = pick_src(id_ex.rs1, ex_mem_hit_ok, ex_mem.rd, wb);
  assign fwd_b = pick_src(id_ex.rs2, ex_mem_hit_ok, ex_mem.rd, wb);

  // load-use, hold decode one cycle
  assign load_in_ex = id_ex.ctrl.mem_read && id_ex.rd != '0;
  assign stall      = load_in_ex && (id_ex.rd == id_rs1 || id_ex.rd == id_rs2);

endmodule

// ==== source/execute_unit.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module execute_unit
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  id_ex_t   id_ex,
  input  fwd_sel_e fwd_a,
  input  fwd_sel_e fwd_b,
  input  wb_t      wb,
  output logic     redirect,
  output xword_t   redirect_pc,
  output ex_mem_t  ex_mem
);

  xword_t op_a;
  xword_t op_b;
  xword_t alu_b;
  xword_t alu_out;
  xword_t ex_result;
  logic   taken;

  function automatic xword_t fwd_mux(input fwd_sel_e sel, input xword_t reg_val,
                                     input xword_t ex_val, input xword_t wb_val);
    case (sel)
      FWD_EX_MEM: return ex_val;
      FWD_MEM_WB: return wb_val;
      default:    return reg_val;
    endcase
  endfunction

  assign op_a  = fwd_mux(fwd_a, id_ex.rs1_data, ex_mem.result, wb.data);
  assign op_b  = fwd_mux(fwd_b, id_ex.rs2_data, ex_mem.result, wb.data);
  assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : op_b;

  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_SUB: alu_out = op_a - alu_b;
      ALU_AND: alu_out = op_a & alu_b;
      ALU_OR:  alu_out = op_a | alu_b;
      ALU_XOR: alu_out = op_a ^ alu_b;
      ALU_SLT: alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
      default: alu_out = op_a + alu_b;
    endcase
  end

  // beq and bne resolve by equality
  assign taken       = id_ex.ctrl.branch && ((op_a == op_b) != id_ex.ctrl.branch_ne);
  assign redirect    = taken || id_ex.ctrl.jump;
  assign redirect_pc = id_ex.pc + id_ex.imm;
  assign ex_result   = id_ex.ctrl.jump ? id_ex.pc + `PC_STEP : alu_out; // link

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem.reg_write  <= 1'b0;
      ex_mem.mem_read   <= 1'b0;
      ex_mem.mem_write  <= 1'b0;
      ex_mem.mem_to_reg <= 1'b0;
    end else begin
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.mem_read   <= id_ex.ctrl.mem_read;
      ex_mem.mem_write  <= id_ex.ctrl.mem_write;
      ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.result     <= ex_result;
      ex_mem.store_data <= op_b;
    end
  end

  // decode drops a bubble behind every redirect
  a_redirect_bubble: assert property (@(posedge clk) disable iff (reset)
    redirect |=> !redirect);

endmodule

// ==== source/mem_wb_unit.sv ====
`timescale 1ns/1ps

module mem_wb_unit
  import rv_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  ex_mem_t ex_mem,
  output xword_t  dmem_addr,
  output xword_t  dmem_wdata,
  output logic    dmem_we,
  input  xword_t  dmem_rdata,
  output xword_t  mem_wb_fwd,
  output wb_t     wb
);

  mem_wb_t mem_wb;
  xword_t  mem_data;

  // data memory reads combinationally, store lands on the next edge
  assign dmem_addr  = ex_mem.result;
  assign dmem_wdata = ex_mem.store_data;
  assign dmem_we    = ex_mem.mem_write;

  assign mem_data = ex_mem.mem_to_reg ? dmem_rdata : ex_mem.result;

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb.reg_write <= 1'b0;
    end else begin
      mem_wb.reg_write <= ex_mem.reg_write;
      mem_wb.rd        <= ex_mem.rd;
      mem_wb.data      <= mem_data;
    end
  end

  assign wb.valid   = mem_wb.reg_write && mem_wb.rd != '0; // x0 writes never retire
  assign wb.rd      = mem_wb.rd;
  assign wb.data    = wb.valid ? mem_wb.data : '0;
  assign mem_wb_fwd = mem_wb.data;

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/1ps

module rv_core
  import rv_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  output xword_t imem_addr,
  input  xword_t imem_data,
  output xword_t dmem_addr,
  output xword_t dmem_wdata,
  output logic   dmem_we,
  input  xword_t dmem_rdata,
  output wb_t    wb
);

  if_id_t    if_id;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  wb_t       wb_fwd;
  xword_t    mem_wb_fwd;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  xword_t    rs1_data;
  xword_t    rs2_data;
  logic      stall;
  logic      redirect;
  xword_t    redirect_pc;
  fwd_sel_e  fwd_a;
  fwd_sel_e  fwd_b;

  // forward path sees the unmasked MEM/WB value
  assign wb_fwd = '{valid: wb.valid, rd: wb.rd, data: mem_wb_fwd};

  fetch_unit i_fetch (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .if_id       (if_id)
  );

  decode_unit i_decode (
    .clk      (clk),
    .reset    (reset),
    .if_id    (if_id),
    .stall    (stall),
    .redirect (redirect),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .id_ex    (id_ex)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .reset    (reset),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  hazard_unit i_hazard (
    .id_rs1 (rs1_addr),
    .id_rs2 (rs2_addr),
    .id_ex  (id_ex),
    .ex_mem (ex_mem),
    .wb     (wb),
    .stall  (stall),
    .fwd_a  (fwd_a),
    .fwd_b  (fwd_b)
  );

  execute_unit i_execute (
    .clk         (clk),
    .reset       (reset),
    .id_ex       (id_ex),
    .fwd_a       (fwd_a),
    .fwd_b       (fwd_b),
    .wb          (wb_fwd),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .ex_mem      (ex_mem)
  );

  mem_wb_unit i_mem_wb (
    .clk        (clk),
    .reset      (reset),
    .ex_mem     (ex_mem),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata),
    .mem_wb_fwd (mem_wb_fwd),
    .wb         (wb)
  );

endmodule

// ==== sim/rv_model.svh ====
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// immediates per instruction format, sign extended
function automatic xword_t imm_i(input xword_t ins);
  return {{20{ins[31]}}, ins[31:20]};
endfunction

function automatic xword_t imm_s(input xword_t ins);
  return {{20{ins[31]}}, ins[31:25], ins[11:7]};
endfunction

function automatic xword_t imm_b(input xword_t ins);
  return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
endfunction

function automatic xword_t imm_j(input xword_t ins);
  return {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
endfunction

// one instruction per step, no pipeline timing at all
task automatic run_model();
  xword_t    arch_regs [0:31];
  xword_t    mem [0:MEM_WORDS-1];
  xword_t    pc;
  xword_t    ins;
  xword_t    a;
  xword_t    b;
  xword_t    res;
  xword_t    addr;
  xword_t    next_pc;
  logic      writes;
  reg_addr_t rd;
  int        steps;
  wb_t       w;
  store_t    st;
  for (int i = 0; i < 32; i++)
    arch_regs[i] = '0;
  for (int i = 0; i < MEM_WORDS; i++)
    mem[i] = dmem_init[i];
  pc    = `RESET_PC;
  steps = 0;
  while (pc != END_PC && steps <= PROG_LEN) begin
    ins     = imem[pc[9:2]];
    rd      = ins[11:7];
    a       = arch_regs[ins[19:15]];
    b       = arch_regs[ins[24:20]];
    next_pc = pc + 32'd4;
    writes  = 1'b0;
    res     = '0;
    case (ins[6:0])
      7'b0110011: begin // register-register
        writes = 1'b1;
        case (ins[14:12])
          3'b000:  res = ins[30] ? a - b : a + b;
          3'b111:  res = a & b;
          3'b110:  res = a | b;
          3'b100:  res = a ^ b;
          default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
      end
      7'b0010011: begin
        writes = 1'b1;
        case (ins[14:12])
          3'b111:  res = a & imm_i(ins);
          3'b110:  res = a | imm_i(ins);
          3'b100:  res = a ^ imm_i(ins);
          default: res = a + imm_i(ins);
        endcase
      end
      7'b0000011: begin
        writes = 1'b1;
        addr   = a + imm_i(ins);
        res    = mem[addr[9:2]];
      end
      7'b0100011: begin
        addr = a + imm_s(ins);
        mem[addr[9:2]] = b;
        st.addr = addr;
        st.data = b;
        exp_st.push_back(st);
      end
      7'b1100011: begin
        if ((a == b) != ins[12]) // funct3 bit 0 flips beq into bne
          next_pc = pc + imm_b(ins);
      end
      7'b1101111: begin
        writes  = 1'b1;
        res     = pc + 32'd4;
        next_pc = pc + imm_j(ins);
      end
      default: fail_run($sformatf("reference model found an unknown opcode at pc 0x%h", pc));
    endcase
    if (writes && rd != '0) begin
      arch_regs[rd] = res;
      w.valid = 1'b1;
      w.rd    = rd;
      w.data  = res;
      exp_wb.push_back(w);
    end
    pc    = next_pc;
    steps = steps + 1;
  end
  if (pc != END_PC)
    fail_run("reference model did not reach the final jump of the program");
endtask

`endif

// ==== sim/tb_rv_core.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tb_rv_core
  import rv_pkg::*;
();

  localparam int     PROG_LEN     = 200;
  localparam int     NUM_INIT     = 7;   // prologue sets x1..x7
  localparam int     MEM_WORDS    = 256;
  localparam int     RESET_CYCLES = 10;
  localparam int     DRAIN_CYCLES = 20;
  localparam int     MAX_CYCLES   = 10 * PROG_LEN + RESET_CYCLES;
  localparam xword_t END_PC       = xword_t'(PROG_LEN * 4);

  typedef struct packed {
    xword_t addr;
    xword_t data;
  } store_t;

  logic   clk = 1'b0;
  logic   reset;
  xword_t imem_addr;
  xword_t imem_data;
  xword_t dmem_addr;
  xword_t dmem_wdata;
  xword_t dmem_rdata;
  logic   dmem_we;
  wb_t    wb;

  xword_t imem [0:MEM_WORDS-1];
  xword_t dmem [0:MEM_WORDS-1];
  xword_t dmem_init [0:MEM_WORDS-1]; // start image for the model
  wb_t    exp_wb [$];
  store_t exp_st [$];
  xword_t rng;
  int     cycle_cnt;

  rv_core i_dut (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata),
    .wb         (wb)
  );

  // both memories answer in the same cycle
  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (!reset && dmem_we)
      dmem[dmem_addr[9:2]] <= dmem_wdata;
  end

  initial begin
    forever #5 clk = ~clk;
  end

  function automatic xword_t xorshift32(input xword_t s);
    xword_t x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic xword_t next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at cycle %0d", cycle_cnt);
  endtask

  `include "rv_model.svh"

  // standard RV32I instruction encoders
  function automatic xword_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic xword_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic xword_t s_type(input logic [11:0] imm, input reg_addr_t rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011}; // base is x0
  endfunction

  function automatic xword_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic xword_t j_type(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic gen_program();
    xword_t      r;
    xword_t      r2;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [3:0]  kind;
    logic [11:0] waddr;
    int          skip;
    for (int i = 0; i < MEM_WORDS; i++) begin
      dmem[i]      = next_rand();
      dmem_init[i] = dmem[i];
      imem[i]      = i_type(12'(i), 5'd0, 3'b000, 5'd0, 7'b0010011); // nop tagged by index
    end
    for (int i = 0; i < NUM_INIT; i++) begin
      r       = next_rand();
      imem[i] = i_type(r[11:0], 5'd0, 3'b000, 5'(i + 1), 7'b0010011);
    end
    for (int i = NUM_INIT; i < PROG_LEN; i++) begin
      r     = next_rand();
      r2    = next_rand();
      rd    = {2'b00, r[2:0]}; // only x0..x7 for dense dependencies
      rs1   = {2'b00, r[5:3]};
      rs2   = {2'b00, r[8:6]};
      kind  = r[12:9];
      waddr = {2'b00, r2[7:0], 2'b00};
      skip  = int'(r2[9:8]) + 1;
      if (skip > PROG_LEN - i)
        skip = PROG_LEN - i; // never past the final jump
      case (kind)
        4'd0, 4'd1, 4'd2, 4'd3: begin
          case (r[15:13])
            3'd0:    imem[i] = r_type(7'h00, rs2, rs1, 3'b000, rd);
            3'd1:    imem[i] = r_type(7'h20, rs2, rs1, 3'b000, rd);
            3'd2:    imem[i] = r_type(7'h00, rs2, rs1, 3'b111, rd);
            3'd3:    imem[i] = r_type(7'h00, rs2, rs1, 3'b110, rd);
            3'd4:    imem[i] = r_type(7'h00, rs2, rs1, 3'b100, rd);
            default: imem[i] = r_type(7'h00, rs2, rs1, 3'b010, rd);
          endcase
        end
        4'd4, 4'd5, 4'd6, 4'd7: begin
          case (r[14:13])
            2'd0:    imem[i] = i_type(r[31:20], rs1, 3'b000, rd, 7'b0010011);
            2'd1:    imem[i] = i_type(r[31:20], rs1, 3'b111, rd, 7'b0010011);
            2'd2:    imem[i] = i_type(r[31:20], rs1, 3'b110, rd, 7'b0010011);
            default: imem[i] = i_type(r[31:20], rs1, 3'b100, rd, 7'b0010011);
          endcase
        end
        4'd8, 4'd9, 4'd10: imem[i] = i_type(waddr, 5'd0, 3'b010, rd, 7'b0000011);
        4'd11, 4'd12:      imem[i] = s_type(waddr, rs2);
        4'd13, 4'd14:      imem[i] = b_type(13'(skip * 4), rs2, rs1, {2'b00, r2[10]});
        default:           imem[i] = j_type(21'(skip * 4), rd);
      endcase
    end
    imem[PROG_LEN] = j_type(21'd0, 5'd0); // jal x0 to itself
  endtask

  task automatic check_wb(input wb_t got);
    wb_t want;
    if (exp_wb.size() == 0) begin
      fail_run($sformatf("write-back to x%0d arrived after all expected writes", got.rd));
    end else begin
      want = exp_wb.pop_front();
      if (got.rd != want.rd)
        fail_run($sformatf("mismatch wb.rd got 0x%h expected 0x%h", got.rd, want.rd));
      else if (got.data != want.data)
        fail_run($sformatf("mismatch wb.data (x%0d) got 0x%h expected 0x%h",
                           got.rd, got.data, want.data));
    end
  endtask

  task automatic check_store(input xword_t addr, input xword_t data);
    store_t want;
    if (exp_st.size() == 0) begin
      fail_run($sformatf("store to 0x%h arrived after all expected stores", addr));
    end else begin
      want = exp_st.pop_front();
      if (addr != want.addr)
        fail_run($sformatf("mismatch dmem_addr got 0x%h expected 0x%h", addr, want.addr));
      else if (data != want.data)
        fail_run($sformatf("mismatch dmem_wdata got 0x%h expected 0x%h", data, want.data));
    end
  endtask

  // outputs are settled half a cycle after the edge
  always @(negedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > MAX_CYCLES) begin
      fail_run("timeout, expected writes and stores did not all retire");
    end else if ($isunknown(wb.valid) || $isunknown(dmem_we)) begin
      fail_run("write-back valid or store strobe is unknown");
    end else if (reset) begin
      if (wb.valid || dmem_we)
        fail_run("write-back or store active while reset is held");
    end else begin
      if (wb.valid)
        check_wb(wb);
      if (dmem_we)
        check_store(dmem_addr, dmem_wdata);
    end
  end

  initial begin
    reset     = 1'b1;
    cycle_cnt = 0;
    rng       = 32'd175;
    gen_program();
    run_model();
    $display("expecting %0d register writes and %0d stores", exp_wb.size(), exp_st.size());
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
    while (exp_wb.size() != 0 || exp_st.size() != 0)
      @(posedge clk);
    repeat (DRAIN_CYCLES) @(posedge clk); // catch stray late outputs
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+source
+incdir+sim
source/rv_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/reg_file.sv
source/hazard_unit.sv
source/execute_unit.sv
source/mem_wb_unit.sv
source/rv_core.sv
sim/tb_rv_core.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' src.f)

obj_dir/Vtb_rv_core: src.f $(SRCS) source/rv_cfg.svh sim/rv_model.svh
	verilator --binary --assert -f src.f --top-module tb_rv_core

run: obj_dir/Vtb_rv_core
	obj_dir/Vtb_rv_core | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
